// ==== Makefile ====
# Verilator flow for the 52x26 booth multiplier

TOP := tb_mul_52x26

.PHONY: lint sim clean

# lint the RTL top level
lint:
	verilator --lint-only --timing -f src.f --top-module mul_52x26_top

obj_dir/V$(TOP): src.f mul_cfg.svh *.sv
	verilator --binary --timing -f src.f --top-module $(TOP) -o V$(TOP)

# run, then judge the log
sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "no pass line in log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== booth_row_gen.sv ====
// radix-4 booth digit decoder and partial product row generator
`timescale 1ns/100ps
`include "mul_cfg.svh"

module booth_row_gen (
  input  logic [`MUL_PP_W-1:0] multiplicand,
  input  logic [2:0]           window,
  output mul_pkg::booth_row_t  row
);

  mul_pkg::booth_sel_e  sel;
  logic [`MUL_PP_W-1:0] dbl;

  // 2A, top bit of multiplicand is always zero so nothing is lost
  assign dbl = {multiplicand[`MUL_PP_W-2:0], 1'b0};

  // ============================================================
  // digit decode
  // ============================================================
  // window is {b[2i+1], b[2i], b[2i-1]}
  always_comb begin
    case (window)
      3'b001,
      3'b010:  sel = mul_pkg::SEL_POS1;
      3'b011:  sel = mul_pkg::SEL_POS2;
      3'b100:  sel = mul_pkg::SEL_NEG2;
      3'b101,
      3'b110:  sel = mul_pkg::SEL_NEG1;
      // 000 and 111 both give zero
      default: sel = mul_pkg::SEL_ZERO;
    endcase
  end

  // ============================================================
  // row select
  // ============================================================
  always_comb begin
    // zero digit, positive sign
    row.product = '0;
    row.hot     = 2'b00;
    row.sign_n  = 1'b1;
    case (sel)
      mul_pkg::SEL_POS1: row.product = multiplicand;
      mul_pkg::SEL_POS2: row.product = dbl;
      mul_pkg::SEL_NEG1: begin
        // -A = ~A + 1
        row.product = ~multiplicand;
        row.hot     = 2'b01;
        row.sign_n  = 1'b0;
      end
      mul_pkg::SEL_NEG2: begin
        // -2A = ~2A + 1 = {~A, 0} + 2
        row.product = {~multiplicand[`MUL_PP_W-2:0], 1'b0};
        row.hot     = 2'b10;
        row.sign_n  = 1'b0;
      end
      default: ;
    endcase
  end

endmodule

// ==== csa_4to2.sv ====
// 4:2 carry-save compressor over a vector, carry out with weight two
`timescale 1ns/100ps
`include "mul_cfg.svh"

module csa_4to2 #(
  parameter int WIDTH = `MUL_DST_W
) (
  input  logic [WIDTH-1:0] in0,
  input  logic [WIDTH-1:0] in1,
  input  logic [WIDTH-1:0] in2,
  input  logic [WIDTH-1:0] in3,
  output logic [WIDTH-1:0] sum,
  output logic [WIDTH-1:0] carry
);

  logic [WIDTH-1:0] maj;
  logic [WIDTH-1:0] xor4;
  logic [WIDTH-1:0] cin;

  // first full adder, carry part
  assign maj = (in0 & in1) |
               (in1 & in2) |
               (in0 & in2);

  // parity of all four inputs
  assign xor4 = in0 ^ in1 ^ in2 ^ in3;

  // majority moves up one bit into the second adder
  // top bit falls off, result is mod 2^WIDTH
  assign cin = {maj[WIDTH-2:0], 1'b0};

  // second full adder
  assign sum = xor4 ^ cin;

  // maj of (in0^in1^in2, in3, cin)
  // caller shifts it left one bit
  assign carry = (xor4 & cin) |
                 (~xor4 & in3);

endmodule

// ==== csa_tree.sv ====
// three-level carry-save tree, 15 rows to 2, with mid and output registers
`timescale 1ns/100ps
`include "mul_cfg.svh"

module csa_tree (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stage1_en,
  input  logic                stage2_en,
  input  mul_pkg::pp_rows_t   rows,
  output mul_pkg::csa_pair_t  result
);

  localparam int W = `MUL_DST_W;

  // level one outputs, index 3 is the 3:2 on rows 12-14
  mul_pkg::dst_row_t   s0 [4];
  mul_pkg::dst_row_t   c0 [4];
  // level two outputs
  mul_pkg::dst_row_t   s1 [2];
  mul_pkg::dst_row_t   c1 [2];

  mul_pkg::csa_quad_t  mid_d;
  mul_pkg::csa_quad_t  mid_q;

  // level three, one bit wider
  logic [W:0]          p2 [4];
  logic [W:0]          s2;
  logic [W:0]          c2;
  mul_pkg::csa_pair_t  out_d;

  // ============================================================
  // level one, 15 to 8
  // ============================================================
  for (genvar j = 0; j < 3; j++) begin : g_lvl1
    csa_4to2 #(.WIDTH(W)) x_csa_lvl1 (
      .in0   (rows.row[4*j]),
      .in1   (rows.row[4*j+1]),
      .in2   (rows.row[4*j+2]),
      .in3   (rows.row[4*j+3]),
      .sum   (s0[j]),
      .carry (c0[j])
    );
  end

  // rows 12-14, plain full adder
  assign s0[3] = rows.row[12] ^ rows.row[13] ^ rows.row[14];
  assign c0[3] = (rows.row[12] & rows.row[13]) |
                 (rows.row[12] & rows.row[14]) |
                 (rows.row[13] & rows.row[14]);

  // ============================================================
  // level two, 8 to 4
  // ============================================================
  // carries pick up their weight here
  for (genvar k = 0; k < 2; k++) begin : g_lvl2
    csa_4to2 #(.WIDTH(W)) x_csa_lvl2 (
      .in0   (s0[2*k]),
      .in1   ({c0[2*k][W-2:0], 1'b0}),
      .in2   (s0[2*k+1]),
      .in3   ({c0[2*k+1][W-2:0], 1'b0}),
      .sum   (s1[k]),
      .carry (c1[k])
    );
  end

  assign mid_d.r0 = s1[0];
  assign mid_d.r1 = c1[0];
  assign mid_d.r2 = s1[1];
  assign mid_d.r3 = c1[1];

  // mid register, loads with the stage one beat
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mid_q <= '0;
    end else if (stage1_en) begin
      mid_q <= mid_d;
    end
  end

  // ============================================================
  // level three, 4 to 2
  // ============================================================
  // sums sign-extended, carries shifted
  assign p2[0] = {mid_q.r0[W-1], mid_q.r0};
  assign p2[1] = {mid_q.r1, 1'b0};
  assign p2[2] = {mid_q.r2[W-1], mid_q.r2};
  assign p2[3] = {mid_q.r3, 1'b0};

  csa_4to2 #(.WIDTH(W + 1)) x_csa_lvl3 (
    .in0   (p2[0]),
    .in1   (p2[1]),
    .in2   (p2[2]),
    .in3   (p2[3]),
    .sum   (s2),
    .carry (c2)
  );

  // widen to output width
  assign out_d.sum   = {s2[W], s2};
  assign out_d.carry = {c2, 1'b0};

  // output register, holds while stage two is idle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (stage2_en) begin
      result <= out_d;
    end
  end

endmodule

// ==== mul_52x26_top.sv ====
// 52x26 unsigned booth multiplier top, two-cycle carry-save pipeline
`timescale 1ns/100ps
`include "mul_cfg.svh"

module mul_52x26_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_vld,
  input  logic [`MUL_A_W-1:0] a,
  input  logic [`MUL_B_W-1:0] b,
  output logic                out_vld,
  output mul_pkg::csa_pair_t  result
);

  // aligned partial product rows, combinational
  mul_pkg::pp_rows_t rows;

  // valid shift register
  // bit 0 marks the mid register, bit 1 the output register
  logic [1:0] vld_q;

  // ============================================================
  // valid pipeline
  // ============================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 2'b00;
    end else begin
      vld_q <= {vld_q[0], in_vld};
    end
  end

  // beat leaves with the output register
  assign out_vld = vld_q[1];

  // ============================================================
  // datapath
  // ============================================================
  pp_array x_pp_array (
    .a    (a),
    .b    (b),
    .rows (rows)
  );

  // mid register takes the incoming beat
  // output register takes the beat sitting in mid
  csa_tree x_csa_tree (
    .clk       (clk),
    .arst_n    (arst_n),
    .stage1_en (in_vld),
    .stage2_en (vld_q[0]),
    .rows      (rows),
    .result    (result)
  );

endmodule

// ==== mul_cfg.svh ====
// multiplier configuration macros for operand, booth row and compressor widths
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// ============================================================
// operand widths
// ============================================================
// multiplicand
`define MUL_A_W    52
// multiplier
`define MUL_B_W    26

// ============================================================
// booth array and tree widths
// ============================================================
// multiplicand plus two zero bits, room for the doubled value
`define MUL_PP_W   54
// radix-4 digits over the zero-extended multiplier
`define MUL_ROWS   14
// compressor row width, levels one and two
`define MUL_DST_W  82
// final carry-save vectors
`define MUL_OUT_W  84

`endif

// ==== mul_pkg.sv ====
// shared types for the booth multiplier: digit select, row and carry-save vectors
`include "mul_cfg.svh"

package mul_pkg;

  // booth digit select, decoded from a 3-bit window
  typedef enum logic [2:0] {
    SEL_ZERO,
    SEL_POS1,
    SEL_POS2,
    SEL_NEG1,
    SEL_NEG2
  } booth_sel_e;

  // one recoded row before alignment
  typedef struct packed {
    // selected multiple, complemented for negative digits
    logic [`MUL_PP_W-1:0] product;
    // +1 correction, bit 0 for -A, bit 1 for -2A
    logic [1:0]           hot;
    // inverted row sign
    logic                 sign_n;
  } booth_row_t;

  // aligned compressor row
  typedef logic [`MUL_DST_W-1:0] dst_row_t;

  // all aligned rows, 14 booth rows plus the trailing hot row
  typedef struct packed {
    dst_row_t [`MUL_ROWS:0] row;
  } pp_rows_t;

  // four rows across the mid register
  typedef struct packed {
    dst_row_t r0;
    dst_row_t r1;
    dst_row_t r2;
    dst_row_t r3;
  } csa_quad_t;

  // final carry-save pair, sum + carry mod 2^84 is the product
  typedef struct packed {
    logic [`MUL_OUT_W-1:0] sum;
    logic [`MUL_OUT_W-1:0] carry;
  } csa_pair_t;

endpackage

// ==== pp_array.sv ====
// booth partial product array: digit windows, 14 row generators, aligned rows
`timescale 1ns/100ps
`include "mul_cfg.svh"

module pp_array (
  input  logic [`MUL_A_W-1:0] a,
  input  logic [`MUL_B_W-1:0] b,
  output mul_pkg::pp_rows_t   rows
);

  // windows span 2 bits per digit plus the appended zero
  localparam int CODE_W = 2 * `MUL_ROWS + 1;
  // one placed row: leading one, sign_n, product, hot of row above
  localparam int SPAN_W = `MUL_PP_W + 4;

  logic [`MUL_PP_W-1:0] multiplicand;
  logic [CODE_W-1:0]    code;
  mul_pkg::booth_row_t  pp [`MUL_ROWS];

  // ============================================================
  // operand extension
  // ============================================================
  // unsigned operands, zero on top
  assign multiplicand = {{(`MUL_PP_W - `MUL_A_W){1'b0}}, a};
  // zero appended below b for the first window
  assign code = {{(CODE_W - `MUL_B_W - 1){1'b0}}, b, 1'b0};

  // ============================================================
  // row generators
  // ============================================================
  for (genvar i = 0; i < `MUL_ROWS; i++) begin : g_row
    booth_row_gen x_booth_row_gen (
      .multiplicand (multiplicand),
      .window       (code[2*i+2 -: 3]),
      .row          (pp[i])
    );
  end

  // ============================================================
  // row placement
  // ============================================================
  always_comb begin
    // first row
    // sign extension folded into {s_n, s, s}
    rows.row[0] = {{(`MUL_DST_W - `MUL_PP_W - 3){1'b0}},
                   pp[0].sign_n,
                   ~pp[0].sign_n,
                   ~pp[0].sign_n,
                   pp[0].product};

    // later rows, 2 bits per digit
    // hot of previous row sits right under this row's product
    for (int i = 1; i < `MUL_ROWS; i++) begin
      rows.row[i] = {{(`MUL_DST_W - SPAN_W){1'b0}},
                     1'b1,
                     pp[i].sign_n,
                     pp[i].product,
                     pp[i-1].hot} << (2 * i - 2);
    end

    // last hot pair gets its own row
    rows.row[`MUL_ROWS] = {{(`MUL_DST_W - 2){1'b0}},
                           pp[`MUL_ROWS-1].hot} << (2 * `MUL_ROWS - 2);
  end

endmodule

// ==== src.f ====
+incdir+.
mul_pkg.sv
booth_row_gen.sv
pp_array.sv
csa_4to2.sv
csa_tree.sv
mul_52x26_top.sv
tb_mul_52x26.sv

// ==== tb_mul_52x26.sv ====
// testbench for the 52x26 booth multiplier, directed table then random beats with gaps
`timescale 1ns/100ps
`include "mul_cfg.svh"

module tb_mul_52x26;

  localparam int TBL_N  = 15;
  localparam int RAND_N = 200;
  // reset, two cycles per beat at worst, then drain margin
  localparam int LIMIT  = 16 + 2 * (TBL_N + RAND_N) + 50;

  // one directed vector
  typedef struct packed {
    logic [`MUL_A_W-1:0]   a;
    logic [`MUL_B_W-1:0]   b;
    logic [`MUL_OUT_W-1:0] prod;
  } vec_t;

  logic                  clk;
  logic                  arst_n;
  logic                  in_vld;
  logic [`MUL_A_W-1:0]   a;
  logic [`MUL_B_W-1:0]   b;
  logic                  out_vld;
  mul_pkg::csa_pair_t    result;

  vec_t                  tbl [TBL_N];
  string                 tbl_name [TBL_N];

  // beats in flight, oldest first
  logic [`MUL_OUT_W-1:0] exp_q [$];
  string                 name_q [$];

  integer                seed;
  int                    cycle_cnt = 0;
  // in_vld seen at the last two falling edges
  logic [1:0]            vld_hist = 2'b00;
  mul_pkg::csa_pair_t    last_res = '0;
  logic [`MUL_OUT_W-1:0] got_prod;

  mul_52x26_top dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_vld  (in_vld),
    .a       (a),
    .b       (b),
    .out_vld (out_vld),
    .result  (result)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ============================================================
  // checking helpers
  // ============================================================
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [`MUL_OUT_W-1:0] exp_v,
                           input logic [`MUL_OUT_W-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("error: %s expected %h actual %h", name, exp_v, act_v);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      stop_with_failure($sformatf("timeout: run went past %0d cycles", LIMIT));
    end
  end

  // ============================================================
  // output monitor, falling edge so outputs are settled
  // ============================================================
  always @(negedge clk) begin
    got_prod = result.sum + result.carry;
    // out_vld is in_vld two cycles late
    check_val("valid_delay", 84'(vld_hist[1]), 84'(out_vld));
    if (out_vld) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("out_vld went high with no beat in flight");
      end else begin
        check_val(name_q.pop_front(), exp_q.pop_front(), got_prod);
        last_res = result;
      end
    end else begin
      // idle cycle, register bank must hold
      check_val("hold_sum", last_res.sum, result.sum);
      check_val("hold_carry", last_res.carry, result.carry);
    end
    vld_hist = {vld_hist[0], in_vld};
  end

  // ============================================================
  // stimulus
  // ============================================================
  task automatic set_vec(input int idx, input string name, input logic [`MUL_A_W-1:0] op_a,
                         input logic [`MUL_B_W-1:0] op_b,
                         input logic [`MUL_OUT_W-1:0] prod);
    tbl_name[idx] = name;
    tbl[idx].a    = op_a;
    tbl[idx].b    = op_b;
    tbl[idx].prod = prod;
  endtask

  // products written from powers of two, not from a multiply
  task automatic load_table();
    set_vec(0, "zero_both", '0, '0, '0);
    set_vec(1, "zero_a", '0, 26'h3ffffff, '0);
    set_vec(2, "zero_b", 52'hfffffffffffff, '0, '0);
    // (2^52-1)(2^26-1)
    set_vec(3, "ones_both", 52'hfffffffffffff, 26'h3ffffff,
            (84'd1 << 78) - (84'd1 << 52) - (84'd1 << 26) + 84'd1);
    set_vec(4, "one_one", 52'h1, 26'h1, 84'd1);
    set_vec(5, "a_msb", 52'h8000000000000, 26'h1, 84'd1 << 51);
    set_vec(6, "b_msb", 52'h1, 26'h2000000, 84'd1 << 25);
    set_vec(7, "both_msb", 52'h8000000000000, 26'h2000000, 84'd1 << 76);
    // digit 0 is +1
    set_vec(8, "digit_pos1", 52'hfffffffffffff, 26'h1, (84'd1 << 52) - 84'd1);
    // -2 then +1
    set_vec(9, "digit_neg2", 52'hfffffffffffff, 26'h2, (84'd1 << 53) - 84'd2);
    // -1 then +1
    set_vec(10, "digit_neg1", 52'hfffffffffffff, 26'h3, (84'd3 << 52) - 84'd3);
    // -2 then +2
    set_vec(11, "digit_pos2", 52'hfffffffffffff, 26'h6, (84'd6 << 52) - 84'd6);
    // long run of -1 digits
    set_vec(12, "digit_neg1_run", 52'hfffffffffffff, 26'h2aaaaaa,
            (84'h2aaaaaa << 52) - 84'h2aaaaaa);
    // long run of +1 digits
    set_vec(13, "digit_pos1_run", 52'h3, 26'h1555555, 84'h3ffffff);
    set_vec(14, "pattern_a", 52'h5555555555555, 26'h3, (84'd1 << 52) - 84'd1);
  endtask

  task automatic send_beat(input string name, input logic [`MUL_A_W-1:0] op_a,
                           input logic [`MUL_B_W-1:0] op_b,
                           input logic [`MUL_OUT_W-1:0] prod);
    in_vld <= 1'b1;
    a      <= op_a;
    b      <= op_b;
    exp_q.push_back(prod);
    name_q.push_back(name);
    @(posedge clk);
  endtask

  task automatic send_random(input string name);
    logic [31:0]         w0;
    logic [31:0]         w1;
    logic [31:0]         w2;
    logic [`MUL_A_W-1:0] ra;
    logic [`MUL_B_W-1:0] rb;
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    ra = {w1[19:0], w0};
    rb = w2[25:0];
    send_beat(name, ra, rb, 84'(ra) * 84'(rb));
  endtask

  // operands flip while idle, nothing may load
  task automatic idle_cycle();
    in_vld <= 1'b0;
    a      <= ~a;
    b      <= ~b;
    @(posedge clk);
  endtask

  initial begin
    logic [31:0] r;
    seed   = 32'hdd82;
    arst_n = 1'b0;
    in_vld = 1'b0;
    a      = '0;
    b      = '0;
    load_table();

    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // directed vectors, back to back
    for (int i = 0; i < TBL_N; i++) begin
      send_beat(tbl_name[i], tbl[i].a, tbl[i].b, tbl[i].prod);
    end
    idle_cycle();

    // random, in_vld high every cycle
    for (int i = 0; i < RAND_N / 2; i++) begin
      send_random($sformatf("rand_b2b_%0d", i));
    end

    // random with idle gaps
    for (int i = RAND_N / 2; i < RAND_N; i++) begin
      r = $random(seed);
      if (r[0]) begin
        idle_cycle();
      end
      send_random($sformatf("rand_gap_%0d", i));
    end
    idle_cycle();

    // drain, then a few idle cycles for the hold check
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    // every mismatch has already stopped the run
    $display("TEST PASS");
    $finish;
  end

endmodule
